// ==== common/video_pkg.sv ====
/*
 * raster constants for the 512 x 262 arcade frame
 * packed structs for horizontal state, vertical state and the output bundle
 */
package video_pkg;

    // every count is 9 bits wide
    localparam int line_w = 9;

    // last pixel of a line, last line of a frame
    localparam logic [line_w-1:0] h_total_m1 = 9'd511;
    localparam logic [line_w-1:0] v_total_m1 = 9'd261;

    // horizontal blank covers 448..511 and 0..63
    localparam logic [line_w-1:0] hb_end   = 9'd64;
    localparam logic [line_w-1:0] hb_start = 9'd448;

    // pre_vb outside lines 14..237, i.e. 224 visible lines
    localparam logic [line_w-1:0] vb_top    = 9'd14;
    localparam logic [line_w-1:0] vb_bottom = 9'd237;

    // lines where the tile engine gets a line_start
    localparam logic [line_w-1:0] line_win_lo = 9'd12;
    localparam logic [line_w-1:0] line_win_hi = 9'd240;

    // vertical sync length in lines
    localparam int vs_len = 4;

    // reset lands at the start of vertical blank
    localparam logic [line_w-1:0] vdump_rst    = 9'd240;
    localparam logic [line_w-1:0] vrender_rst  = 9'd241;
    localparam logic [line_w-1:0] vrender1_rst = 9'd242;

    // horizontal side, h_timing to raster_sync
    typedef struct packed {
        logic [line_w-1:0] hdump;
        logic              hb;
        logic              hs;
        logic              hs_begin;   // hdump at sync start, with cen
        logic              line_end;   // hdump at 511, with cen
    } h_state_t;

    // vertical side, v_timing to raster_sync
    typedef struct packed {
        logic [line_w-1:0] vdump;
        logic [line_w-1:0] vrender;
        logic [line_w-1:0] vrender1;
        logic              vb;
        logic              pre_vb;
        logic              vs_window;   // vdump inside the sync lines
        logic              line_window; // vdump inside the line_start lines
        logic              frame_start;
    } v_state_t;

    // top level output bundle
    typedef struct packed {
        logic [line_w-1:0] hdump;
        logic [line_w-1:0] vdump;
        logic [line_w-1:0] vrender;
        logic [line_w-1:0] vrender1;
        logic              hs;
        logic              vs;
        logic              hb;
        logic              vb;
        logic              pre_vb;
        logic              line_start;
        logic              line_inc;
        logic              frame_start;
    } video_timing_t;

endpackage

// ==== video_timing/h_timing.sv ====
/*
 * horizontal timing: pixel counter, registered blank, sync flip-flop
 * and the hs_begin / line_end strobes
 */
`timescale 1ns/1ps

module h_timing
    import video_pkg::*;
#(
    parameter int HS_START = 487,
    parameter int HS_LEN   = 38
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     cen,
    output h_state_t h_state
);

    // sync edges as 9-bit positions
    // truncation to line_w wraps the end modulo 512
    localparam logic [line_w-1:0] hs_start_pos = line_w'(HS_START);
    localparam logic [line_w-1:0] hs_end_pos   = line_w'(HS_START + HS_LEN);

    logic [line_w-1:0] hdump_q;
    logic              hb_q;
    logic              hs_q;
    logic              at_hs_start;
    logic              at_hs_end;
    logic              at_line_end;
    logic              blank_now;

    // position decodes on the current count
    assign at_hs_start = (hdump_q == hs_start_pos);
    assign at_hs_end   = (hdump_q == hs_end_pos);
    assign at_line_end = (hdump_q == h_total_m1);

    // blank test, registered below so hb lags hdump by one cen
    assign blank_now = (hdump_q >= hb_start) || (hdump_q < hb_end);

    always_ff @(posedge clk) begin
        if (rst) begin
            hdump_q <= '0;
            hb_q    <= 1'b1;
            hs_q    <= 1'b0;
        end else if (cen) begin
            // 9-bit counter wraps 511 -> 0 on its own
            hdump_q <= hdump_q + 1'b1;
            hb_q    <= blank_now;
            if (at_hs_start) begin
                hs_q <= 1'b1;
            end
            // end test wins if both positions coincide
            if (at_hs_end) begin
                hs_q <= 1'b0;
            end
        end
    end

    // strobes only live for the enabled cycle
    assign h_state.hdump    = hdump_q;
    assign h_state.hb       = hb_q;
    assign h_state.hs       = hs_q;
    assign h_state.hs_begin = cen && at_hs_start;
    assign h_state.line_end = cen && at_line_end;

    // counter frozen while cen is low
    a_hdump_frozen : assert property (
        @(posedge clk) disable iff (rst)
        !cen |=> $stable(hdump_q)
    );

endmodule

// ==== video_timing/v_timing.sv ====
/*
 * vertical timing: three-stage line pipeline, two-stage blank shift,
 * sync window and line window decodes, frame-start pulse
 */
`timescale 1ns/1ps

module v_timing
    import video_pkg::*;
#(
    parameter int VS_START   = 251,
    parameter int FRAME_LINE = 255
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     cen,
    input  logic     line_end,
    output v_state_t v_state
);

    localparam logic [line_w-1:0] vs_first   = line_w'(VS_START);
    localparam logic [line_w-1:0] vs_last    = line_w'(VS_START + vs_len - 1);
    localparam logic [line_w-1:0] frame_line = line_w'(FRAME_LINE);

    // vrender1 leads, vrender one line behind, vdump two lines behind
    logic [line_w-1:0] vrender1_q;
    logic [line_w-1:0] vrender_q;
    logic [line_w-1:0] vdump_q;

    // blank shift: pre_vb -> vb_dly -> vb
    logic              pre_vb_q;
    logic              vb_dly_q;
    logic              vb_q;
    logic              frame_start_q;
    logic              pre_vb_now;

    // lines outside the visible 224
    assign pre_vb_now = (vdump_q < vb_top) || (vdump_q > vb_bottom);

    always_ff @(posedge clk) begin
        if (rst) begin
            vrender1_q    <= vrender1_rst;
            vrender_q     <= vrender_rst;
            vdump_q       <= vdump_rst;
            pre_vb_q      <= 1'b1;
            vb_dly_q      <= 1'b1;
            vb_q          <= 1'b1;
            frame_start_q <= 1'b0;
        end else if (cen) begin
            // early blank tracks vdump on every pixel
            pre_vb_q <= pre_vb_now;
            if (line_end) begin
                vrender1_q <= (vrender1_q == v_total_m1) ? '0 : vrender1_q + 1'b1;
                vrender_q  <= vrender1_q;
                vdump_q    <= vrender_q;
                // two lines of lag behind pre_vb
                vb_dly_q   <= pre_vb_q;
                vb_q       <= vb_dly_q;
                // old vrender1 picks the frame-start line
                frame_start_q <= (vrender1_q == frame_line);
            end else begin
                frame_start_q <= 1'b0;
            end
        end
    end

    assign v_state.vdump       = vdump_q;
    assign v_state.vrender     = vrender_q;
    assign v_state.vrender1    = vrender1_q;
    assign v_state.vb          = vb_q;
    assign v_state.pre_vb      = pre_vb_q;
    // sync lines, sampled by raster_sync at the hs rise
    assign v_state.vs_window   = (vdump_q >= vs_first) && (vdump_q <= vs_last);
    // lines where line_start is allowed
    assign v_state.line_window = (vdump_q > line_win_lo) && (vdump_q < line_win_hi);
    assign v_state.frame_start = frame_start_q;

    // leading line counter stays inside the frame
    a_vrender1_range : assert property (
        @(posedge clk) disable iff (rst)
        vrender1_q <= v_total_m1
    );

    // pulse is gone by the next enabled cycle
    a_frame_start_len : assert property (
        @(posedge clk) disable iff (rst)
        (frame_start_q && cen) |=> !frame_start_q
    );

endmodule

// ==== src/raster_sync.sv ====
/*
 * raster sync: merges horizontal and vertical state into the output bundle,
 * vertical sync retimed to the hs rise, line strobes
 */
`timescale 1ns/1ps

module raster_sync
    import video_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          cen,
    input  h_state_t      h_state,
    input  v_state_t      v_state,
    output video_timing_t timing
);

    logic vs_q;
    logic line_inc_q;
    logic line_start_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            vs_q         <= 1'b0;
            line_inc_q   <= 1'b0;
            line_start_q <= 1'b0;
        end else if (cen) begin
            // one cen period after hdump was 511
            line_inc_q   <= h_state.line_end;
            // same, but only on lines the tile engine draws
            line_start_q <= h_state.line_end && v_state.line_window;
            // vs only moves on the hs rise
            if (h_state.hs_begin) begin
                vs_q <= v_state.vs_window;
            end
        end
    end

    // counts and blanks go straight through, no added latency
    assign timing.hdump       = h_state.hdump;
    assign timing.vdump       = v_state.vdump;
    assign timing.vrender     = v_state.vrender;
    assign timing.vrender1    = v_state.vrender1;
    assign timing.hs          = h_state.hs;
    assign timing.hb          = h_state.hb;
    assign timing.vb          = v_state.vb;
    assign timing.pre_vb      = v_state.pre_vb;
    assign timing.frame_start = v_state.frame_start;

    // retimed sync and line strobes
    assign timing.vs          = vs_q;
    assign timing.line_inc    = line_inc_q;
    assign timing.line_start  = line_start_q;

    // line_start is a filtered line_inc
    a_start_has_inc : assert property (
        @(posedge clk) disable iff (rst)
        line_start_q |-> line_inc_q
    );

    // any vs edge lands on the same clock as an hs rise from h_timing
    a_vs_on_hs_rise : assert property (
        @(posedge clk) disable iff (rst)
        !$stable(vs_q) |-> $rose(h_state.hs)
    );

endmodule

// ==== src/crt_timing.sv ====
/*
 * crt timing top: horizontal and vertical timing side by side,
 * merged by raster_sync into one registered bundle
 */
`timescale 1ns/1ps

module crt_timing
    import video_pkg::*;
#(
    parameter int HS_START   = 487,  // larger moves the picture left
    parameter int HS_LEN     = 38,
    parameter int VS_START   = 251,  // larger moves the picture up
    parameter int FRAME_LINE = 255
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          cen,
    output video_timing_t timing
);

    h_state_t h_state;
    v_state_t v_state;

    // pixel counter, blank and hsync
    h_timing #(
        .HS_START (HS_START),
        .HS_LEN   (HS_LEN)
    ) u_h_timing (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .h_state (h_state)
    );

    // line pipeline steps once per line
    v_timing #(
        .VS_START   (VS_START),
        .FRAME_LINE (FRAME_LINE)
    ) u_v_timing (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .line_end (h_state.line_end),
        .v_state  (v_state)
    );

    raster_sync u_raster_sync (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .h_state (h_state),
        .v_state (v_state),
        .timing  (timing)
    );

endmodule

// ==== test/tb_checks.svh ====
/*
 * compare tasks for the crt timing testbench
 * error, timeout and per-test result bookkeeping
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int   err_count  = 0;
int   test_errs  = 0;
int   test_count = 0;
int   test_fails = 0;
logic timed_out  = 1'b0;

task automatic note_error();
    err_count++;
    test_errs++;
endtask

// whole output bundle against the reference model
task automatic check_bundle(input string name, input video_timing_t got,
                            input video_timing_t exp);
    if (got !== exp) begin
        $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
        note_error();
    end
endtask

// single strobe or level
task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
        note_error();
    end
endtask

// 9-bit count or position
task automatic check_count(input string name, input logic [line_w-1:0] got,
                           input logic [line_w-1:0] exp);
    if (got !== exp) begin
        $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
        note_error();
    end
endtask

task automatic timeout_hit(input string what);
    $display("Timeout: gave up waiting for %s at %0t", what, $time);
    timed_out = 1'b1;
    note_error();
endtask

// one result line per test
task automatic finish_test(input string name);
    test_count++;
    if (test_errs == 0) begin
        $display("test %s: ok", name);
    end else begin
        test_fails++;
        $display("test %s: failed with %0d errors", name, test_errs);
    end
    test_errs = 0;
endtask

`endif

// ==== test/tb_crt_timing.sv ====
/*
 * testbench for crt_timing: clock, reset, random cen,
 * reference raster model from the cen count, directed tests
 */
`timescale 1ns/1ps

module tb_crt_timing
    import video_pkg::*;
();

    localparam int hs_start   = 487;
    localparam int hs_len     = 38;
    localparam int vs_start   = 251;
    localparam int frame_line = 255;
    localparam int line_len   = int'(h_total_m1) + 1;
    localparam int frame_len  = int'(v_total_m1) + 1;
    // cycle bounds for the wait loops, cen is high about half the time
    localparam int line_limit  = 8 * line_len;
    localparam int frame_limit = 3 * line_len * frame_len;

    logic          clk;
    logic          rst;
    logic          cen;
    video_timing_t timing;
    // cen pulses applied since reset
    int            cen_count;
    integer        seed = 32'h56194d81;

    `include "tb_checks.svh"

    crt_timing #(
        .HS_START   (hs_start),
        .HS_LEN     (hs_len),
        .VS_START   (vs_start),
        .FRAME_LINE (frame_line)
    ) u_crt_timing (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .timing (timing)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst) begin
            cen_count <= 0;
        end else if (cen) begin
            cen_count <= cen_count + 1;
        end
    end

    function automatic logic hblank_at(input int p);
        return (p >= int'(hb_start)) || (p < int'(hb_end));
    endfunction

    function automatic logic pre_vb_at(input int v);
        return (v < int'(vb_top)) || (v > int'(vb_bottom));
    endfunction

    function automatic logic in_line_window(input int v);
        return (v > int'(line_win_lo)) && (v < int'(line_win_hi));
    endfunction

    function automatic logic in_vs_window(input int v);
        return (v >= vs_start) && (v < vs_start + vs_len);
    endfunction

    // vdump after j line wraps since reset
    function automatic int vdump_line(input int j);
        return (int'(vdump_rst) + j) % frame_len;
    endfunction

    // expected bundle after n cen pulses
    function automatic video_timing_t model_at(input int n);
        video_timing_t e;
        int            k;
        int            p;
        int            hs_end;
        logic          hs_on;
        e          = '0;
        k          = n / line_len;
        e.hdump    = line_w'(n % line_len);
        e.vrender1 = line_w'((int'(vrender1_rst) + k) % frame_len);
        e.vrender  = line_w'((int'(vrender_rst) + k) % frame_len);
        e.vdump    = line_w'(vdump_line(k));
        e.hb       = 1'b1;
        e.pre_vb   = 1'b1;
        e.vb       = 1'b1;
        if (n > 0) begin
            // p is the hdump that the last cen saw
            p      = (n - 1) % line_len;
            hs_end = (hs_start + hs_len) % line_len;
            if (hs_end > hs_start) begin
                hs_on = (p >= hs_start) && (p < hs_end);
            end else begin
                hs_on = (p >= hs_start) || (p < hs_end);
            end
            e.hb     = hblank_at(p);
            e.hs     = (n - 1 >= hs_start) && hs_on;
            e.pre_vb = pre_vb_at(vdump_line((n - 1) / line_len));
            // two lines behind pre_vb
            if (k >= 2) begin
                e.vb = pre_vb_at(vdump_line(k - 2));
            end
            e.line_inc = (n % line_len == 0);
            if (e.line_inc) begin
                e.line_start  = in_line_window(vdump_line(k - 1));
                e.frame_start = ((int'(vrender1_rst) + k - 1) % frame_len) == frame_line;
            end
            // vs sampled at the last hs rise
            if (n > hs_start) begin
                e.vs = in_vs_window(vdump_line((n - 1 - hs_start) / line_len));
            end
        end
        return e;
    endfunction

    // called on a falling edge, checks one cycle later
    task automatic advance(input logic en);
        cen = en;
        @(negedge clk);
        check_bundle("timing", timing, model_at(cen_count));
    endtask

    task automatic step_random(output logic en);
        int r;
        r  = $random(seed);
        en = r[0];
        advance(en);
    endtask

    task automatic test_reset_hold();
        video_timing_t rst_val;
        video_timing_t held;
        int            i;
        rst_val          = '0;
        rst_val.vdump    = vdump_rst;
        rst_val.vrender  = vrender_rst;
        rst_val.vrender1 = vrender1_rst;
        rst_val.hb       = 1'b1;
        rst_val.vb       = 1'b1;
        rst_val.pre_vb   = 1'b1;
        check_bundle("timing after reset", timing, rst_val);
        held = timing;
        for (i = 0; i < 64; i++) begin
            advance(1'b0);
            check_bundle("timing with cen low", timing, held);
        end
        finish_test("reset and hold");
    endtask

    // hdump steps, line_inc and hb over two lines
    task automatic test_hline();
        video_timing_t prev;
        logic          en;
        int            pulses;
        int            i;
        pulses = 0;
        for (i = 0; i < 2 * line_limit && pulses < 2 * line_len; i++) begin
            prev = timing;
            step_random(en);
            if (en) begin
                pulses++;
                check_count("hdump", timing.hdump,
                            line_w'((int'(prev.hdump) + 1) % line_len));
                check_bit("line_inc", timing.line_inc, prev.hdump == h_total_m1);
                check_bit("hb", timing.hb, hblank_at(int'(prev.hdump)));
            end else begin
                check_count("hdump with cen low", timing.hdump, prev.hdump);
            end
        end
        if (pulses < 2 * line_len) begin
            timeout_hit("two lines of cen pulses");
        end
        finish_test("horizontal count");
    endtask

    task automatic test_hsync();
        video_timing_t prev;
        logic          en;
        logic          rose;
        logic          fell;
        logic          wrapped;
        int            cnt;
        int            i;
        rose    = 1'b0;
        fell    = 1'b0;
        wrapped = 1'b0;
        cnt     = 0;
        for (i = 0; i < line_limit && !rose; i++) begin
            prev = timing;
            step_random(en);
            rose = !prev.hs && timing.hs;
        end
        if (!rose) begin
            timeout_hit("hs to rise");
        end else begin
            check_count("hdump before hs rise", prev.hdump, line_w'(hs_start));
            // count the cen pulses up to and including the fall
            for (i = 0; i < line_limit && !fell; i++) begin
                step_random(en);
                if (en) begin
                    cnt++;
                end
                if (timing.hdump == '0) begin
                    wrapped = 1'b1;
                end
                fell = !timing.hs;
            end
            if (!fell) begin
                timeout_hit("hs to fall");
            end else begin
                check_count("hs length", line_w'(cnt), line_w'(hs_len));
                check_bit("hs across line wrap", wrapped, 1'b1);
            end
        end
        finish_test("horizontal sync");
    endtask

    task automatic test_frame();
        video_timing_t prev;
        logic          en;
        int            lines;
        int            i;
        lines = 0;
        for (i = 0; i < frame_limit && lines < frame_len; i++) begin
            prev = timing;
            step_random(en);
            // pipeline offsets hold on every cycle
            check_count("vrender", timing.vrender,
                        line_w'((int'(timing.vrender1) + frame_len - 1) % frame_len));
            check_count("vdump", timing.vdump,
                        line_w'((int'(timing.vrender) + frame_len - 1) % frame_len));
            if (en && timing.line_inc) begin
                lines++;
                check_count("vrender1", timing.vrender1,
                            line_w'((int'(prev.vrender1) + 1) % frame_len));
                check_bit("line_start", timing.line_start, in_line_window(int'(prev.vdump)));
            end
            // mid line, the blanks have settled for this vdump
            if (en && timing.hdump == line_w'(line_len / 2)) begin
                check_bit("pre_vb", timing.pre_vb, pre_vb_at(int'(timing.vdump)));
                check_bit("vb", timing.vb,
                          pre_vb_at((int'(timing.vdump) + frame_len - 2) % frame_len));
            end
        end
        if (lines < frame_len) begin
            timeout_hit("a whole frame of lines");
        end
        finish_test("vertical frame");
    endtask

    task automatic test_vsync();
        video_timing_t prev;
        logic          en;
        logic          rose;
        logic          done;
        int            i;
        rose = 1'b0;
        done = 1'b0;
        for (i = 0; i < 2 * frame_limit && !done; i++) begin
            prev = timing;
            step_random(en);
            if (timing.vs != prev.vs) begin
                check_bit("hs rise with vs edge", !prev.hs && timing.hs, 1'b1);
                if (timing.vs) begin
                    rose = 1'b1;
                    check_count("vdump at vs rise", timing.vdump, line_w'(vs_start));
                end else begin
                    done = rose;
                    check_count("vdump at vs fall", timing.vdump, line_w'(vs_start + vs_len));
                end
            end
        end
        if (!done) begin
            timeout_hit("a vs rise and fall");
        end
        finish_test("vertical sync");
    endtask

    task automatic test_frame_start();
        video_timing_t prev;
        logic          en;
        int            lines;
        int            pulses;
        int            i;
        lines  = 0;
        pulses = 0;
        for (i = 0; i < frame_limit && lines < frame_len; i++) begin
            prev = timing;
            step_random(en);
            if (en && timing.line_inc) begin
                lines++;
            end
            if (en && timing.frame_start) begin
                pulses++;
                check_count("vrender1 before frame_start", prev.vrender1, line_w'(frame_line));
                check_bit("line_inc with frame_start", timing.line_inc, 1'b1);
            end
            // gone after one cen period
            if (en && prev.frame_start) begin
                check_bit("frame_start length", timing.frame_start, 1'b0);
            end
        end
        if (lines < frame_len) begin
            timeout_hit("a frame for frame_start");
        end else begin
            check_count("frame_start pulses", line_w'(pulses), 9'd1);
        end
        finish_test("frame start");
    endtask

    initial begin
        rst = 1'b1;
        cen = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset_hold();
        if (!timed_out) begin
            test_hline();
        end
        if (!timed_out) begin
            test_hsync();
        end
        if (!timed_out) begin
            test_frame();
        end
        if (!timed_out) begin
            test_vsync();
        end
        if (!timed_out) begin
            test_frame_start();
        end
        $display("%0d tests run, %0d failed, %0d errors", test_count, test_fails, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+test
common/video_pkg.sv
video_timing/h_timing.sv
video_timing/v_timing.sv
src/raster_sync.sv
src/crt_timing.sv
test/tb_crt_timing.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the crt timing testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f verilog.f \
    --top-module tb_crt_timing \
    -o tb_crt_timing

./obj_dir/tb_crt_timing | tee sim.log

# the log decides pass or fail
if grep -qF '** PASS **' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
